// ==== include/ring_config.svh ====
`ifndef RING_CONFIG_SVH
`define RING_CONFIG_SVH

// ring geometry
`define RING_STOPS 4 // storage stops on the chain
`define STOP_WORDS 16 // words held by each stop

// datapath widths
`define RING_DATA_W 32 // wishbone data width
// word address, log2(stops*words) plus one spare bit
// the spare top bit opens an unmapped window for fault testing
`define RING_ADDR_W 7

`endif

// ==== hdl/ringPkg.sv ====
`default_nettype none

// ring message format shared by every hop on the chain
package ringPkg;

	// opcode carried on each link, idle means empty slot
	typedef enum logic [1:0]
	{
		opIdle = 2'b00, // no message on this link
		opLoad = 2'b01, // read request, not yet claimed
		opStore = 2'b10, // write request, not yet claimed
		opResp = 2'b11 // claimed by a stop, heading to retire
	} ringOpm;

	// stamped by the bridge, checked again at retire
	typedef logic [7:0] ringSeq;

	// stop identity, compared with upper address bits
	typedef logic [7:0] ringNodeId;

endpackage

`default_nettype wire

// ==== hdl/faultPkg.sv ====
`default_nettype none

// exception codes reported back to the requester
package faultPkg;

	// bit 15 set raises an interrupt, clear is non-critical
	typedef logic [15:0] faultCode;

	localparam faultCode faultNone = 16'h0000; // clean completion
	localparam faultCode faultUnmapped = 16'h0001; // no stop owns the address
	localparam faultCode faultBadSeq = 16'h8002; // response out of order, interrupt class

endpackage

`default_nettype wire

// ==== hdl/ringBridge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ring_config.svh"

// wishbone classic slave with one request in flight
module ringBridge
(
	input wire clock,
	input wire rst,
	input wire cyc, // bus cycle open
	input wire stb, // request strobe
	input wire we, // store when set
	input wire [`RING_ADDR_W-1:0] adr, // word address
	input wire [`RING_DATA_W-1:0] datWr, // store data
	input wire done, // retire finished the request
	output ringPkg::ringOpm msgOpm, // link 0 opcode
	output ringPkg::ringSeq msgSeq, // link 0 sequence
	output logic [`RING_ADDR_W-1:0] msgAddr, // link 0 address
	output logic [`RING_DATA_W-1:0] msgData, // link 0 data
	output ringPkg::ringSeq expSeq // sequence retire should see
);

	logic busy; // request on the ring
	logic accept; // take request this edge
	ringPkg::ringSeq seqCnt; // next sequence to stamp

	// stb is ignored while busy since the master holds it
	assign accept = cyc && stb && !busy;

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			seqCnt <= '0;
			expSeq <= '0;
			msgOpm <= ringPkg::opIdle;
		end
		else
		begin
			msgOpm <= ringPkg::opIdle; // message lives one cycle only
			if (accept)
			begin
				busy <= 1'b1;
				msgOpm <= we ? ringPkg::opStore : ringPkg::opLoad;
				expSeq <= seqCnt; // remember for retire check
				seqCnt <= seqCnt + ringPkg::ringSeq'(1);
			end
			else if (done)
				busy <= 1'b0; // stale stb on the done edge is skipped
		end
	end

	// payload captured with the request
	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			msgSeq <= seqCnt;
			msgAddr <= adr;
			msgData <= datWr;
		end
	end

	// one message per request and nothing more until retire reports back
	assert property (@(posedge clock) disable iff (rst)
		(msgOpm != ringPkg::opIdle) |=> (msgOpm == ringPkg::opIdle) until_with done);

endmodule

`default_nettype wire

// ==== hdl/ringStop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ring_config.svh"

// storage stop, claims requests whose upper address bits equal its id
module ringStop
#(
	parameter ringPkg::ringNodeId StopId = '0 // who are we
)
(
	input wire clock,
	input wire rst,
	input ringPkg::ringOpm inOpm, // upstream link
	input ringPkg::ringSeq inSeq,
	input wire [`RING_ADDR_W-1:0] inAddr,
	input wire [`RING_DATA_W-1:0] inData,
	output ringPkg::ringOpm outOpm, // downstream link, registered
	output ringPkg::ringSeq outSeq,
	output logic [`RING_ADDR_W-1:0] outAddr,
	output logic [`RING_DATA_W-1:0] outData
);

	localparam int WordBits = $clog2(`STOP_WORDS); // low address bits select the word

	logic [`RING_DATA_W-1:0] mem [`STOP_WORDS]; // local word store
	logic [WordBits-1:0] wordIdx; // word within this stop
	logic isReq; // unclaimed load or store
	logic hit; // request belongs here

	assign wordIdx = inAddr[WordBits-1:0];
	assign isReq = (inOpm == ringPkg::opLoad) || (inOpm == ringPkg::opStore);
	// upper bits zero extended to the id width
	assign hit = isReq &&
		(ringPkg::ringNodeId'(inAddr[`RING_ADDR_W-1:WordBits]) == StopId);

	// words come up zero after reset
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			for (int k = 0; k < `STOP_WORDS; k++)
				mem[k] <= '0;
		end
		else if (hit && (inOpm == ringPkg::opStore))
			mem[wordIdx] <= inData; // store lands here
	end

	// opcode, claimed requests turn into responses
	always_ff @(posedge clock)
	begin
		if (rst)
			outOpm <= ringPkg::opIdle;
		else
			outOpm <= hit ? ringPkg::opResp : inOpm;
	end

	// payload moves one hop per cycle
	always_ff @(posedge clock)
	begin
		outSeq <= inSeq;
		outAddr <= inAddr;
		if (hit && (inOpm == ringPkg::opLoad))
			outData <= mem[wordIdx]; // load returns stored word
		else
			outData <= inData; // store echoes written data, others pass
	end

	// a response from an earlier stop must reach the next hop untouched
	assert property (@(posedge clock) disable iff (rst)
		(inOpm == ringPkg::opResp) |=>
			(outOpm == ringPkg::opResp) && (outSeq == $past(inSeq)) &&
			(outAddr == $past(inAddr)) && (outData == $past(inData)));

endmodule

`default_nettype wire

// ==== hdl/ringRetire.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ring_config.svh"

// end of chain turning the arriving message into ack or err
module ringRetire
(
	input wire clock,
	input wire rst,
	input ringPkg::ringOpm inOpm, // last link
	input ringPkg::ringSeq inSeq,
	input wire [`RING_ADDR_W-1:0] inAddr,
	input wire [`RING_DATA_W-1:0] inData,
	input ringPkg::ringSeq expSeq, // sequence of request in flight
	output logic ack, // wishbone ack for one cycle
	output logic err, // wishbone err for one cycle
	output logic [`RING_DATA_W-1:0] datRd, // load data
	output faultPkg::faultCode faultOut, // last completion code
	output logic done // frees the bridge
);

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			ack <= 1'b0;
			err <= 1'b0;
			done <= 1'b0;
			faultOut <= faultPkg::faultNone;
		end
		else
		begin
			ack <= 1'b0; // pulses by default
			err <= 1'b0;
			done <= 1'b0;
			case (inOpm)
				ringPkg::opResp:
				begin
					done <= 1'b1;
					if (inSeq == expSeq)
					begin
						ack <= 1'b1;
						faultOut <= faultPkg::faultNone;
					end
					else
					begin
						err <= 1'b1; // stale or foreign response
						faultOut <= faultPkg::faultBadSeq;
					end
				end
				ringPkg::opLoad, ringPkg::opStore:
				begin
					done <= 1'b1; // nobody claimed it
					err <= 1'b1;
					faultOut <= faultPkg::faultUnmapped;
				end
				default:; // idle slot
			endcase
		end
	end

	// load data follows each response
	always_ff @(posedge clock)
	begin
		if (inOpm == ringPkg::opResp)
			datRd <= inData;
	end

	// completion is a single cycle of exactly one of ack or err
	assert property (@(posedge clock) disable iff (rst)
		(ack || err) |-> !(ack && err) ##1 !(ack || err));

	// stops must have claimed everything inside the mapped window
	assert property (@(posedge clock) disable iff (rst)
		((inOpm == ringPkg::opLoad) || (inOpm == ringPkg::opStore)) |->
			(inAddr >= (`RING_STOPS * `STOP_WORDS)));

endmodule

`default_nettype wire

// ==== hdl/ringMemTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ring_config.svh"

// wishbone memory built as a ring of storage stops
module ringMemTop
(
	input wire clock,
	input wire rst,
	input wire cyc,
	input wire stb,
	input wire we,
	input wire [`RING_ADDR_W-1:0] adr,
	input wire [`RING_DATA_W-1:0] datWr,
	output logic [`RING_DATA_W-1:0] datRd,
	output logic ack,
	output logic err,
	output logic [15:0] faultOut // exception code, bit 15 is interrupt
);

	// link k feeds stop k, link RING_STOPS feeds retire
	ringPkg::ringOpm linkOpm [`RING_STOPS+1];
	ringPkg::ringSeq linkSeq [`RING_STOPS+1];
	logic [`RING_ADDR_W-1:0] linkAddr [`RING_STOPS+1];
	logic [`RING_DATA_W-1:0] linkData [`RING_STOPS+1];

	ringPkg::ringSeq expSeq; // bridge to retire
	logic done; // retire to bridge

	ringBridge bridge
	(
		.clock(clock), .rst(rst),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr), .datWr(datWr),
		.done(done),
		.msgOpm(linkOpm[0]), .msgSeq(linkSeq[0]),
		.msgAddr(linkAddr[0]), .msgData(linkData[0]),
		.expSeq(expSeq)
	);

	for (genvar i = 0; i < `RING_STOPS; i++)
	begin : gStop
		ringStop #(.StopId(ringPkg::ringNodeId'(i))) stop
		(
			.clock(clock), .rst(rst),
			.inOpm(linkOpm[i]), .inSeq(linkSeq[i]),
			.inAddr(linkAddr[i]), .inData(linkData[i]),
			.outOpm(linkOpm[i+1]), .outSeq(linkSeq[i+1]),
			.outAddr(linkAddr[i+1]), .outData(linkData[i+1])
		);
	end

	ringRetire retire
	(
		.clock(clock), .rst(rst),
		.inOpm(linkOpm[`RING_STOPS]), .inSeq(linkSeq[`RING_STOPS]),
		.inAddr(linkAddr[`RING_STOPS]), .inData(linkData[`RING_STOPS]),
		.expSeq(expSeq),
		.ack(ack), .err(err), .datRd(datRd), .faultOut(faultOut), .done(done)
	);

	// fixed latency through the chain, one hop per stop plus retire
	assert property (@(posedge clock) disable iff (rst)
		(linkOpm[0] != ringPkg::opIdle) |-> ##(`RING_STOPS+1) (ack || err));

endmodule

`default_nettype wire

// ==== verif/ringMemTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ring_config.svh"

module ringMemTb;

	localparam int MappedWords = `RING_STOPS * `STOP_WORDS; // words owned by stops
	localparam int AddrSpan = 1 << `RING_ADDR_W; // whole word address space
	localparam int Latency = `RING_STOPS + 1; // accept edge to ack edge
	localparam int LatLimit = Latency + 10; // give up on a single request
	localparam int ResetLoads = 8;
	localparam int RandomOps = 200;
	localparam int AliasOps = 8; // unmapped store plus mapped load each
	localparam int Requests = ResetLoads + RandomOps + 2 * AliasOps + 2 * MappedWords;
	localparam int CycleLimit = (Requests * (`RING_STOPS + 4)) + 100;

	logic clock;
	logic rst;
	logic cyc;
	logic stb;
	logic we;
	logic [`RING_ADDR_W-1:0] adr;
	logic [`RING_DATA_W-1:0] datWr;
	logic [`RING_DATA_W-1:0] datRd;
	logic ack;
	logic err;
	faultPkg::faultCode faultOut;

	logic [`RING_DATA_W-1:0] model [int]; // reference memory where absent words read as zero
	int errors = 0;
	int checks = 0;
	int cycleCnt = 0;

	ringMemTop dut
	(
		.clock(clock),
		.rst(rst),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datWr(datWr),
		.datRd(datRd),
		.ack(ack),
		.err(err),
		.faultOut(faultOut)
	);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock; // 20 ns period
	end

	// run length guard
	always @(posedge clock)
	begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= CycleLimit)
		begin
			$display("timeout: run did not finish within %0d cycles", CycleLimit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// completion must be exactly one of ack or err
	always @(negedge clock)
	begin
		if (!rst && ack && err)
		begin
			$display("Error at %0t: ack and err high together", $time);
			errors++;
		end
	end

	// drop the request lines for n edges
	task automatic idleBus(input int n);
		repeat (n)
		begin
			@(posedge clock);
			cyc <= 1'b0;
			stb <= 1'b0;
		end
	endtask

	// one wishbone access checked against the model
	task automatic runAccess(input logic isWrite, input logic [`RING_ADDR_W-1:0] addr,
		input logic [`RING_DATA_W-1:0] data);
		int lat;
		logic finished;
		logic mapped;
		logic [`RING_DATA_W-1:0] expData;
		mapped = (int'(addr) < MappedWords);
		expData = model.exists(int'(addr)) ? model[int'(addr)] : '0;
		@(posedge clock);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= isWrite;
		adr <= addr;
		datWr <= data;
		@(posedge clock); // accepting edge with the bridge idle
		lat = 0;
		finished = 1'b0;
		while (!finished)
		begin
			@(posedge clock);
			lat++;
			@(negedge clock); // outputs settled
			if (ack || err)
				finished = 1'b1;
			else if (lat > LatLimit)
			begin
				$display("request to address %0h was never completed", addr);
				errors++;
				return;
			end
		end
		checks++;
		if (lat != Latency)
		begin
			$display("Error at %0t: adr %0h completed after %0d cycles, expected %0d",
				$time, addr, lat, Latency);
			errors++;
		end
		if (mapped)
		begin
			if (!ack || err)
			begin
				$display("Error at %0t: adr %0h expected ack, got err", $time, addr);
				errors++;
			end
			if (faultOut !== faultPkg::faultNone)
			begin
				$display("Error at %0t: adr %0h fault %0h on ack", $time, addr, faultOut);
				errors++;
			end
			if (!isWrite && (datRd !== expData))
			begin
				$display("Error at %0t: load adr %0h got %0h expected %0h",
					$time, addr, datRd, expData);
				errors++;
			end
			if (isWrite)
				model[int'(addr)] = data; // store landed
		end
		else
		begin
			if (!err || ack)
			begin
				$display("Error at %0t: unmapped adr %0h expected err", $time, addr);
				errors++;
			end
			if (faultOut !== faultPkg::faultUnmapped)
			begin
				$display("Error at %0t: unmapped adr %0h fault %0h expected %0h",
					$time, addr, faultOut, faultPkg::faultUnmapped);
				errors++;
			end
		end
	endtask

	// pattern spread over every address bit
	function automatic logic [`RING_DATA_W-1:0] sweepData(input int a);
		return (`RING_DATA_W'(a) * `RING_DATA_W'(32'h9e3779b1)) ^ `RING_DATA_W'(32'h5a5a0000);
	endfunction

	initial
	begin
		int a;
		int idle;
		logic isWrite;
		void'($urandom(32'hd8d82f46)); // single seed for the run
		rst <= 1'b1;
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
		adr <= '0;
		datWr <= '0;
		repeat (3) @(posedge clock);
		rst <= 1'b0;

		// quiet bus after reset
		repeat (3)
		begin
			@(negedge clock);
			checks++;
			if ((ack !== 1'b0) || (err !== 1'b0))
			begin
				$display("Error at %0t: ack or err high after reset", $time);
				errors++;
			end
		end

		// fresh memory reads back zero
		repeat (ResetLoads)
			runAccess(1'b0, `RING_ADDR_W'($urandom_range(MappedWords - 1)), '0);

		// random mix of mapped and unmapped accesses with idle gaps
		for (int n = 0; n < RandomOps; n++)
		begin
			isWrite = 1'($urandom_range(1));
			if ($urandom_range(3) == 0)
				a = MappedWords + $urandom_range(AddrSpan - MappedWords - 1);
			else
				a = $urandom_range(MappedWords - 1);
			runAccess(isWrite, `RING_ADDR_W'(a), $urandom());
			idle = $urandom_range(2);
			idleBus(idle);
		end

		// unmapped stores must not touch the aliased mapped word
		for (int n = 0; n < AliasOps; n++)
		begin
			a = $urandom_range(MappedWords - 1);
			runAccess(1'b1, `RING_ADDR_W'(a + MappedWords), $urandom());
			runAccess(1'b0, `RING_ADDR_W'(a), '0);
		end
		idleBus(1);

		// back to back sweep over every stop and word
		for (a = 0; a < MappedWords; a++)
			runAccess(1'b1, `RING_ADDR_W'(a), sweepData(a));
		for (a = 0; a < MappedWords; a++)
			runAccess(1'b0, `RING_ADDR_W'(a), '0);
		idleBus(2);

		$display("ringMemTb done: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
hdl/ringPkg.sv
hdl/faultPkg.sv
hdl/ringBridge.sv
hdl/ringStop.sv
hdl/ringRetire.sv
hdl/ringMemTop.sv
verif/ringMemTb.sv

// ==== Bender.yml ====
package:
  name: ring_mem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/ringPkg.sv
      - hdl/faultPkg.sv
      - hdl/ringBridge.sv
      - hdl/ringStop.sv
      - hdl/ringRetire.sv
      - hdl/ringMemTop.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/ringMemTb.sv
